//--- memctrl_cfg.svh
// Cache memory controller configuration
// Geometry of the directory and data arrays

`ifndef MEMCTRL_CFG_SVH
`define MEMCTRL_CFG_SVH

// Associativity
`define MC_WAYS 4

// Number of sets in the directory
`define MC_SETS 16

// Address tag kept per entry
`define MC_TAG_WIDTH 8

// Data word, always a whole number of bytes
`define MC_WORD_WIDTH 32

// Words held by one cache line
`define MC_LINE_WORDS 4

`endif

//--- memctrl_pkg.sv
// Cache memory controller types
// Way masks, set and word indexes, directory entries and data words

package memctrl_pkg;

    `include "memctrl_cfg.svh"

    typedef logic [`MC_WAYS-1:0] way_vec_t;
    typedef logic [$clog2(`MC_SETS)-1:0] set_t;
    typedef logic [`MC_TAG_WIDTH-1:0] tag_t;
    typedef logic [$clog2(`MC_LINE_WORDS)-1:0] word_idx_t;

    // One directory entry per set and way
    typedef struct packed {
        logic valid;
        logic dirty;
        tag_t tag;
    } dir_entry_t;

    typedef logic [`MC_WORD_WIDTH-1:0] data_word_t;
    typedef logic [`MC_WORD_WIDTH/8-1:0] data_be_t;

    // Data RAM row is set then word
    typedef logic [$bits(set_t)+$bits(word_idx_t)-1:0] data_addr_t;

endpackage

//--- dir_state_if.sv
// Directory state seen by the victim selector
// Valid bits of the last lookup and refill events

`timescale 1ns/1ps

interface dir_state_if;
    import memctrl_pkg::*;

    way_vec_t valid_vec;
    set_t     read_set;
    logic     refill;
    set_t     refill_set;
    way_vec_t refill_way;

    modport ctrl (
        output valid_vec,
        output read_set,
        output refill,
        output refill_set,
        output refill_way
    );

    modport victim (
        input valid_vec,
        input read_set,
        input refill,
        input refill_set,
        input refill_way
    );

endinterface

//--- cache_sram.sv
// Single-port synchronous RAM with lane write enables
// Registered read, the read port holds during writes

`timescale 1ns/1ps

module cache_sram #(
    parameter int unsigned ADDR_WIDTH = 4,
    parameter int unsigned LANE_WIDTH = 8,
    parameter int unsigned LANES      = 4
) (
    input  logic                        clk_i,
    input  logic                        rst_ni,
    input  logic                        cs_i,
    input  logic [LANES-1:0]            we_i,
    input  logic [ADDR_WIDTH-1:0]       addr_i,
    input  logic [LANES*LANE_WIDTH-1:0] wdata_i,
    output logic [LANES*LANE_WIDTH-1:0] rdata_o
);
    localparam int unsigned DEPTH = 1 << ADDR_WIDTH;

    logic [LANES-1:0][LANE_WIDTH-1:0] mem_q [DEPTH];
    logic [LANES*LANE_WIDTH-1:0]      rdata_q;

    always_ff @(posedge clk_i) begin : mem_write
        if (cs_i) begin
            for (int l = 0; l < LANES; l++) begin
                if (we_i[l]) begin
                    mem_q[addr_i][l] <= wdata_i[l*LANE_WIDTH +: LANE_WIDTH];
                end
            end
        end
    end

    // Only a pure read updates the output register
    always_ff @(posedge clk_i or negedge rst_ni) begin : mem_read
        if (!rst_ni) begin
            rdata_q <= '0;
        end else if (cs_i && (we_i == '0)) begin
            rdata_q <= mem_q[addr_i];
        end
    end

    assign rdata_o = rdata_q;

endmodule

//--- dir_ctrl.sv
// Cache directory controller
// Clears all sets after reset, then serves lookups, refills and updates
// Hit ways and dirty bit come one cycle after the lookup

`timescale 1ns/1ps

`include "memctrl_cfg.svh"

module dir_ctrl (
    input  logic                  clk_i,
    input  logic                  rst_ni,
    input  logic                  match_i,
    input  memctrl_pkg::set_t     match_set_i,
    input  memctrl_pkg::tag_t     match_tag_i,
    input  logic                  refill_i,
    input  memctrl_pkg::set_t     refill_set_i,
    input  memctrl_pkg::way_vec_t refill_way_i,
    input  memctrl_pkg::tag_t     refill_tag_i,
    input  logic                  updt_i,
    input  memctrl_pkg::set_t     updt_set_i,
    input  memctrl_pkg::way_vec_t updt_way_i,
    input  logic                  updt_valid_i,
    input  logic                  updt_dirty_i,
    input  memctrl_pkg::tag_t     updt_tag_i,
    output logic                  ready_o,
    output memctrl_pkg::way_vec_t hit_way_o,
    output logic                  hit_dirty_o,
    dir_state_if.ctrl             state_o
);
    import memctrl_pkg::*;

    localparam int unsigned ENTRY_WIDTH = $bits(dir_entry_t);

    logic                         init_q;
    set_t                         init_set_q;
    set_t                         dir_addr;
    way_vec_t                     dir_cs;
    way_vec_t                     dir_we;
    dir_entry_t                   dir_wentry;
    dir_entry_t [`MC_WAYS-1:0]    dir_rentry;
    tag_t                         match_tag_q;
    set_t                         read_set_q;
    way_vec_t                     valid_vec;
    way_vec_t                     dirty_vec;

    // Init sequencer, one set per cycle
    always_ff @(posedge clk_i or negedge rst_ni) begin : init_seq
        if (!rst_ni) begin
            init_q     <= 1'b0;
            init_set_q <= '0;
        end else if (!init_q) begin
            init_set_q <= init_set_q + 1'b1;
            init_q     <= (init_set_q == set_t'(`MC_SETS - 1));
        end
    end

    assign ready_o = init_q;

    // Request mux, match first, then refill, then update
    always_comb begin : dir_req_mux
        dir_addr   = read_set_q;
        dir_cs     = '0;
        dir_we     = '0;
        dir_wentry = '0;
        if (!init_q) begin
            dir_addr = init_set_q;
            dir_cs   = '1;
            dir_we   = '1;
        end else if (match_i) begin
            dir_addr = match_set_i;
            dir_cs   = '1;
        end else if (refill_i) begin
            dir_addr   = refill_set_i;
            dir_cs     = refill_way_i;
            dir_we     = refill_way_i;
            dir_wentry = '{valid: 1'b1, dirty: 1'b0, tag: refill_tag_i};
        end else if (updt_i) begin
            dir_addr   = updt_set_i;
            dir_cs     = updt_way_i;
            dir_we     = updt_way_i;
            dir_wentry = '{valid: updt_valid_i, dirty: updt_dirty_i, tag: updt_tag_i};
        end
    end

    for (genvar w = 0; w < `MC_WAYS; w++) begin : gen_dir_ram
        cache_sram #(
            .ADDR_WIDTH ($bits(set_t)),
            .LANE_WIDTH (ENTRY_WIDTH),
            .LANES      (1)
        ) u_dir_ram (
            .clk_i   (clk_i),
            .rst_ni  (rst_ni),
            .cs_i    (dir_cs[w]),
            .we_i    (dir_we[w]),
            .addr_i  (dir_addr),
            .wdata_i (dir_wentry),
            .rdata_o (dir_rentry[w])
        );

        assign valid_vec[w] = dir_rentry[w].valid;
        assign dirty_vec[w] = dir_rentry[w].dirty;
        assign hit_way_o[w] = valid_vec[w] & (dir_rentry[w].tag == match_tag_q);
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin : read_set_reg
        if (!rst_ni) begin
            read_set_q <= '0;
        end else if (init_q && match_i) begin
            read_set_q <= match_set_i;
        end
    end

    // Tag compared against the RAM output next cycle
    always_ff @(posedge clk_i) begin : match_tag_reg
        if (match_i) begin
            match_tag_q <= match_tag_i;
        end
    end

    assign hit_dirty_o = |(hit_way_o & dirty_vec);

    assign state_o.valid_vec  = valid_vec;
    assign state_o.read_set   = read_set_q;
    assign state_o.refill     = init_q & refill_i & ~match_i;
    assign state_o.refill_set = refill_set_i;
    assign state_o.refill_way = refill_way_i;

endmodule

//--- victim_sel.sv
// Victim way selection
// First invalid way of the looked-up set, else a per-set round-robin way

`timescale 1ns/1ps

`include "memctrl_cfg.svh"

module victim_sel (
    input  logic                  clk_i,
    input  logic                  rst_ni,
    dir_state_if.victim           state_i,
    output memctrl_pkg::way_vec_t victim_way_o
);
    import memctrl_pkg::*;

    localparam int unsigned PTR_WIDTH = $clog2(`MC_WAYS);

    typedef logic [PTR_WIDTH-1:0] ptr_t;

    ptr_t     ptr_q [`MC_SETS];
    ptr_t     refill_idx;
    way_vec_t invalid_ways;
    way_vec_t first_invalid;

    always_comb begin : refill_encode
        refill_idx = '0;
        for (int w = 0; w < `MC_WAYS; w++) begin
            if (state_i.refill_way[w]) begin
                refill_idx = ptr_t'(w);
            end
        end
    end

    // Pointer moves past the way just refilled
    always_ff @(posedge clk_i or negedge rst_ni) begin : ptr_update
        if (!rst_ni) begin
            for (int s = 0; s < `MC_SETS; s++) begin
                ptr_q[s] <= '0;
            end
        end else if (state_i.refill) begin
            if (refill_idx == ptr_t'(`MC_WAYS - 1)) begin
                ptr_q[state_i.refill_set] <= '0;
            end else begin
                ptr_q[state_i.refill_set] <= refill_idx + 1'b1;
            end
        end
    end

    assign invalid_ways  = ~state_i.valid_vec;
    // Isolate the lowest set bit
    assign first_invalid = invalid_ways & (~invalid_ways + way_vec_t'(1));

    assign victim_way_o = (|invalid_ways) ? first_invalid :
                          way_vec_t'(1) << ptr_q[state_i.read_set];

endmodule

//--- data_ctrl.sv
// Cache data array controller
// One RAM per way, word reads with a way select one cycle later,
// byte-enabled request writes and full-word refill writes

`timescale 1ns/1ps

`include "memctrl_cfg.svh"

module data_ctrl (
    input  logic                    clk_i,
    input  logic                    rst_ni,
    input  logic                    read_i,
    input  memctrl_pkg::set_t       read_set_i,
    input  memctrl_pkg::word_idx_t  read_word_i,
    input  memctrl_pkg::way_vec_t   read_way_i,
    input  logic                    write_i,
    input  memctrl_pkg::set_t       write_set_i,
    input  memctrl_pkg::word_idx_t  write_word_i,
    input  memctrl_pkg::way_vec_t   write_way_i,
    input  memctrl_pkg::data_word_t write_data_i,
    input  memctrl_pkg::data_be_t   write_be_i,
    input  logic                    refill_i,
    input  memctrl_pkg::set_t       refill_set_i,
    input  memctrl_pkg::word_idx_t  refill_word_i,
    input  memctrl_pkg::way_vec_t   refill_way_i,
    input  memctrl_pkg::data_word_t refill_data_i,
    output memctrl_pkg::data_word_t read_data_o,
    output logic                    rd_wr_conflict_o
);
    import memctrl_pkg::*;

    localparam int unsigned BYTES = $bits(data_be_t);

    logic                       wr_en;
    set_t                       wr_set;
    word_idx_t                  wr_word;
    way_vec_t                   wr_way;
    data_word_t                 wr_data;
    data_be_t                   wr_be;
    data_addr_t                 rd_addr;
    data_addr_t                 wr_addr;
    data_word_t [`MC_WAYS-1:0]  rdata;
    way_vec_t                   read_way_q;

    // Refill wins over a request write
    always_comb begin : write_mux
        wr_set  = '0;
        wr_word = '0;
        wr_way  = '0;
        wr_data = '0;
        wr_be   = '0;
        if (refill_i) begin
            wr_set  = refill_set_i;
            wr_word = refill_word_i;
            wr_way  = refill_way_i;
            wr_data = refill_data_i;
            wr_be   = '1;
        end else if (write_i) begin
            wr_set  = write_set_i;
            wr_word = write_word_i;
            wr_way  = write_way_i;
            wr_data = write_data_i;
            wr_be   = write_be_i;
        end
    end

    assign wr_en   = refill_i | write_i;
    assign rd_addr = {read_set_i, read_word_i};
    assign wr_addr = {wr_set, wr_word};

    for (genvar w = 0; w < `MC_WAYS; w++) begin : gen_data_ram
        logic             wr_sel;
        logic [BYTES-1:0] ram_we;
        data_addr_t       ram_addr;

        assign wr_sel   = wr_en & wr_way[w];
        assign ram_we   = wr_sel ? wr_be : '0;
        assign ram_addr = wr_sel ? wr_addr : rd_addr;

        cache_sram #(
            .ADDR_WIDTH ($bits(data_addr_t)),
            .LANE_WIDTH (8),
            .LANES      (BYTES)
        ) u_data_ram (
            .clk_i   (clk_i),
            .rst_ni  (rst_ni),
            .cs_i    (read_i | wr_sel),
            .we_i    (ram_we),
            .addr_i  (ram_addr),
            .wdata_i (wr_data),
            .rdata_o (rdata[w])
        );
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin : read_way_reg
        if (!rst_ni) begin
            read_way_q <= '0;
        end else if (read_i) begin
            read_way_q <= read_way_i;
        end
    end

    // One-hot way select on the RAM outputs
    always_comb begin : read_mux
        read_data_o = '0;
        for (int w = 0; w < `MC_WAYS; w++) begin
            if (read_way_q[w]) begin
                read_data_o = read_data_o | rdata[w];
            end
        end
    end

    assign rd_wr_conflict_o = read_i & write_i & (read_word_i == write_word_i);

endmodule

//--- memctrl_top.sv
// Cache directory and data RAM controller
// Ties the directory, victim selector and data array together

`timescale 1ns/1ps

module memctrl_top (
    input  logic                    clk_i,
    input  logic                    rst_ni,
    output logic                    ready_o,

    input  logic                    dir_match_i,
    input  memctrl_pkg::set_t       dir_match_set_i,
    input  memctrl_pkg::tag_t       dir_match_tag_i,
    output memctrl_pkg::way_vec_t   dir_hit_way_o,
    output logic                    dir_hit_dirty_o,
    output memctrl_pkg::way_vec_t   dir_victim_way_o,

    input  logic                    dir_refill_i,
    input  memctrl_pkg::set_t       dir_refill_set_i,
    input  memctrl_pkg::way_vec_t   dir_refill_way_i,
    input  memctrl_pkg::tag_t       dir_refill_tag_i,

    input  logic                    dir_updt_i,
    input  memctrl_pkg::set_t       dir_updt_set_i,
    input  memctrl_pkg::way_vec_t   dir_updt_way_i,
    input  logic                    dir_updt_valid_i,
    input  logic                    dir_updt_dirty_i,
    input  memctrl_pkg::tag_t       dir_updt_tag_i,

    input  logic                    data_read_i,
    input  memctrl_pkg::set_t       data_read_set_i,
    input  memctrl_pkg::word_idx_t  data_read_word_i,
    input  memctrl_pkg::way_vec_t   data_read_way_i,
    output memctrl_pkg::data_word_t data_read_data_o,

    input  logic                    data_write_i,
    input  memctrl_pkg::set_t       data_write_set_i,
    input  memctrl_pkg::word_idx_t  data_write_word_i,
    input  memctrl_pkg::way_vec_t   data_write_way_i,
    input  memctrl_pkg::data_word_t data_write_data_i,
    input  memctrl_pkg::data_be_t   data_write_be_i,

    input  logic                    data_refill_i,
    input  memctrl_pkg::set_t       data_refill_set_i,
    input  memctrl_pkg::word_idx_t  data_refill_word_i,
    input  memctrl_pkg::way_vec_t   data_refill_way_i,
    input  memctrl_pkg::data_word_t data_refill_data_i,
    output logic                    rd_wr_conflict_o
);

    dir_state_if dir_state ();

    dir_ctrl u_dir_ctrl (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .match_i      (dir_match_i),
        .match_set_i  (dir_match_set_i),
        .match_tag_i  (dir_match_tag_i),
        .refill_i     (dir_refill_i),
        .refill_set_i (dir_refill_set_i),
        .refill_way_i (dir_refill_way_i),
        .refill_tag_i (dir_refill_tag_i),
        .updt_i       (dir_updt_i),
        .updt_set_i   (dir_updt_set_i),
        .updt_way_i   (dir_updt_way_i),
        .updt_valid_i (dir_updt_valid_i),
        .updt_dirty_i (dir_updt_dirty_i),
        .updt_tag_i   (dir_updt_tag_i),
        .ready_o      (ready_o),
        .hit_way_o    (dir_hit_way_o),
        .hit_dirty_o  (dir_hit_dirty_o),
        .state_o      (dir_state)
    );

    victim_sel u_victim_sel (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .state_i      (dir_state),
        .victim_way_o (dir_victim_way_o)
    );

    data_ctrl u_data_ctrl (
        .clk_i            (clk_i),
        .rst_ni           (rst_ni),
        .read_i           (data_read_i),
        .read_set_i       (data_read_set_i),
        .read_word_i      (data_read_word_i),
        .read_way_i       (data_read_way_i),
        .write_i          (data_write_i),
        .write_set_i      (data_write_set_i),
        .write_word_i     (data_write_word_i),
        .write_way_i      (data_write_way_i),
        .write_data_i     (data_write_data_i),
        .write_be_i       (data_write_be_i),
        .refill_i         (data_refill_i),
        .refill_set_i     (data_refill_set_i),
        .refill_word_i    (data_refill_word_i),
        .refill_way_i     (data_refill_way_i),
        .refill_data_i    (data_refill_data_i),
        .read_data_o      (data_read_data_o),
        .rd_wr_conflict_o (rd_wr_conflict_o)
    );

endmodule

//--- memctrl_assertions.sv
// Protocol checks for the cache memory controller
// Request exclusivity, hit way shape and ready stability

`timescale 1ns/1ps

module memctrl_assertions (
    input logic                  clk_i,
    input logic                  rst_ni,
    input logic                  ready_i,
    input logic                  match_i,
    input logic                  refill_i,
    input logic                  updt_i,
    input memctrl_pkg::way_vec_t hit_way_i
);

    // At most one directory request per cycle
    req_exclusive: assert property (@(posedge clk_i) disable iff (!rst_ni)
        $onehot0({match_i, refill_i, updt_i}))
        else $error("directory requests overlap");

    hit_onehot: assert property (@(posedge clk_i) disable iff (!rst_ni)
        $onehot0(hit_way_i))
        else $error("lookup hit more than one way");

    // Once initialized, the directory stays ready
    ready_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
        ready_i |=> ready_i)
        else $error("ready dropped after init");

endmodule

bind memctrl_top memctrl_assertions u_assertions (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .ready_i   (ready_o),
    .match_i   (dir_match_i),
    .refill_i  (dir_refill_i),
    .updt_i    (dir_updt_i),
    .hit_way_i (dir_hit_way_o)
);

//--- tb_memctrl.sv
// Testbench for the cache directory and data RAM controller
// Builds a table of operations from a reference model and applies it with checks

`timescale 1ns/1ps

`include "memctrl_cfg.svh"

module tb_memctrl;
    import memctrl_pkg::*;

    localparam int   CLK_HALF   = 50;
    localparam int   RST_CYCLES = 5;
    localparam int   INIT_LIMIT = 20;
    localparam int   OP_MATCH   = 0;
    localparam int   OP_REFILL  = 1;
    localparam int   OP_UPDT    = 2;
    localparam int   OP_FILL    = 3;
    localparam int   OP_WRITE   = 4;
    localparam int   OP_READ    = 5;
    localparam int   OP_RDWR    = 6;
    localparam set_t DIR_SET    = 4'd3;
    localparam set_t OTHER_SET  = 4'd10;
    localparam set_t DATA_SET   = 4'd5;

    typedef struct {
        int         op;
        set_t       set;
        int         way;
        tag_t       tag;
        logic       valid;
        logic       dirty;
        word_idx_t  word;
        int         rd_way;
        word_idx_t  rd_word;
        data_word_t data;
        data_be_t   be;
        way_vec_t   exp_hit;
        logic       exp_dirty;
        way_vec_t   exp_victim;
        data_word_t exp_data;
        logic       exp_conf;
    } row_t;

    logic       clk_i, rst_ni, ready_o, dir_hit_dirty_o, rd_wr_conflict_o;
    logic       dir_match_i, dir_refill_i, dir_updt_i, dir_updt_valid_i, dir_updt_dirty_i;
    logic       data_read_i, data_write_i, data_refill_i;
    set_t       dir_match_set_i, dir_refill_set_i, dir_updt_set_i;
    set_t       data_read_set_i, data_write_set_i, data_refill_set_i;
    tag_t       dir_match_tag_i, dir_refill_tag_i, dir_updt_tag_i;
    way_vec_t   dir_refill_way_i, dir_updt_way_i, dir_hit_way_o, dir_victim_way_o;
    way_vec_t   data_read_way_i, data_write_way_i, data_refill_way_i;
    word_idx_t  data_read_word_i, data_write_word_i, data_refill_word_i;
    data_word_t data_write_data_i, data_refill_data_i, data_read_data_o;
    data_be_t   data_write_be_i;

    // Reference model
    logic        m_valid [`MC_SETS][`MC_WAYS];
    logic        m_dirty [`MC_SETS][`MC_WAYS];
    tag_t        m_tag   [`MC_SETS][`MC_WAYS];
    int          m_ptr   [`MC_SETS];
    data_word_t  m_data  [`MC_WAYS][`MC_SETS*`MC_LINE_WORDS];

    row_t        rows[$];
    logic [31:0] lfsr;
    int          errors;
    int          checks;
    logic        table_done;

    memctrl_top UUT (.*);

    always #(CLK_HALF) clk_i = ~clk_i;

    // Fibonacci LFSR with taps 32 22 2 1
    function automatic logic [31:0] lfsr_bits(int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            r    = {r[30:0], fb};
        end
        return r;
    endfunction

    // Low bits carry the way so tags in one set never collide
    function automatic tag_t random_tag(int w);
        return tag_t'((lfsr_bits(6) << 2) | w);
    endfunction

    function automatic row_t blank_row(int op, set_t s);
        row_t r;
        r     = '{default: '0};
        r.op  = op;
        r.set = s;
        return r;
    endfunction

    task automatic model_write(set_t s, int w, word_idx_t wd, data_word_t d, data_be_t be);
        for (int b = 0; b < $bits(data_be_t); b++) begin
            if (be[b]) begin
                m_data[w][{s, wd}][b*8 +: 8] = d[b*8 +: 8];
            end
        end
    endtask

    task automatic lookup_entry(set_t s, tag_t t);
        row_t r;
        logic found;
        r     = blank_row(OP_MATCH, s);
        r.tag = t;
        found = 1'b0;
        for (int w = 0; w < `MC_WAYS; w++) begin
            r.exp_hit[w] = m_valid[s][w] && (m_tag[s][w] == t);
            r.exp_dirty  = r.exp_dirty | (r.exp_hit[w] & m_dirty[s][w]);
            if (!m_valid[s][w] && !found) begin
                r.exp_victim[w] = 1'b1;
                found           = 1'b1;
            end
        end
        // Full set falls back to the round-robin pointer
        if (!found) begin
            r.exp_victim[m_ptr[s]] = 1'b1;
        end
        rows.push_back(r);
    endtask

    task automatic dir_refill_entry(set_t s, int w, tag_t t);
        row_t r;
        r             = blank_row(OP_REFILL, s);
        r.way         = w;
        r.tag         = t;
        m_valid[s][w] = 1'b1;
        m_dirty[s][w] = 1'b0;
        m_tag[s][w]   = t;
        m_ptr[s]      = (w + 1) % `MC_WAYS;
        rows.push_back(r);
    endtask

    task automatic dir_update_entry(set_t s, int w, logic v, logic d);
        row_t r;
        r             = blank_row(OP_UPDT, s);
        r.way         = w;
        r.valid       = v;
        r.dirty       = d;
        r.tag         = m_tag[s][w];
        m_valid[s][w] = v;
        m_dirty[s][w] = d;
        rows.push_back(r);
    endtask

    task automatic word_fill_entry(set_t s, int w, word_idx_t wd, data_word_t d);
        row_t r;
        r                  = blank_row(OP_FILL, s);
        r.way              = w;
        r.word             = wd;
        r.data             = d;
        m_data[w][{s, wd}] = d;
        rows.push_back(r);
    endtask

    task automatic byte_write_entry(set_t s, int w, word_idx_t wd, data_word_t d, data_be_t be);
        row_t r;
        r      = blank_row(OP_WRITE, s);
        r.way  = w;
        r.word = wd;
        r.data = d;
        r.be   = be;
        model_write(s, w, wd, d, be);
        rows.push_back(r);
    endtask

    task automatic word_read_entry(set_t s, int w, word_idx_t wd);
        row_t r;
        r          = blank_row(OP_READ, s);
        r.rd_way   = w;
        r.rd_word  = wd;
        r.exp_data = m_data[w][{s, wd}];
        rows.push_back(r);
    endtask

    // Read and write to different ways in one cycle
    task automatic read_write_entry(set_t s, int ww, word_idx_t wwd, int rw, word_idx_t rwd);
        row_t r;
        r          = blank_row(OP_RDWR, s);
        r.way      = ww;
        r.word     = wwd;
        r.data     = lfsr_bits(32);
        r.be       = data_be_t'(lfsr_bits(4));
        r.rd_way   = rw;
        r.rd_word  = rwd;
        r.exp_data = m_data[rw][{s, rwd}];
        r.exp_conf = (wwd == rwd);
        model_write(s, ww, wwd, r.data, r.be);
        rows.push_back(r);
    endtask

    task automatic build_table();
        tag_t t;
        for (int s = 0; s < `MC_SETS; s++) begin
            m_ptr[s] = 0;
            for (int w = 0; w < `MC_WAYS; w++) begin
                m_valid[s][w] = 1'b0;
                m_dirty[s][w] = 1'b0;
                m_tag[s][w]   = '0;
            end
        end
        for (int s = 0; s < `MC_SETS; s++) begin
            lookup_entry(set_t'(s), random_tag(s % `MC_WAYS));
        end
        // Refill in victim order and look up a hit and a miss
        for (int k = 0; k < `MC_WAYS; k++) begin
            t = random_tag(k);
            lookup_entry(DIR_SET, t);
            dir_refill_entry(DIR_SET, k, t);
            lookup_entry(DIR_SET, t);
            lookup_entry(DIR_SET, t ^ 8'h80);
        end
        lookup_entry(DIR_SET, m_tag[DIR_SET][1]);
        t = random_tag(0);
        dir_refill_entry(DIR_SET, 0, t);
        lookup_entry(DIR_SET, t);
        dir_refill_entry(OTHER_SET, 2, random_tag(2));
        lookup_entry(OTHER_SET, m_tag[OTHER_SET][2]);
        lookup_entry(DIR_SET, m_tag[DIR_SET][3]);
        dir_update_entry(DIR_SET, 2, 1'b1, 1'b1);
        lookup_entry(DIR_SET, m_tag[DIR_SET][2]);
        dir_update_entry(DIR_SET, 1, 1'b0, 1'b0);
        lookup_entry(DIR_SET, m_tag[DIR_SET][1]);
        // Data array
        for (int w = 0; w < `MC_WAYS; w++) begin
            for (int i = 0; i < `MC_LINE_WORDS; i++) begin
                word_fill_entry(DATA_SET, w, word_idx_t'(i), lfsr_bits(32));
            end
        end
        for (int n = 0; n < 6; n++) begin
            byte_write_entry(DATA_SET, n % `MC_WAYS, word_idx_t'((n * 3) % 4),
                             lfsr_bits(32), data_be_t'(lfsr_bits(4)));
        end
        for (int w = 0; w < `MC_WAYS; w++) begin
            for (int i = 0; i < `MC_LINE_WORDS; i++) begin
                word_read_entry(DATA_SET, w, word_idx_t'(i));
            end
        end
        read_write_entry(DATA_SET, 0, 2'd1, 2, 2'd1);
        read_write_entry(DATA_SET, 1, 2'd3, 3, 2'd0);
        read_write_entry(DATA_SET, 2, 2'd2, 0, 2'd2);
        read_write_entry(DATA_SET, 3, 2'd0, 1, 2'd2);
        word_read_entry(DATA_SET, 0, 2'd1);
        word_read_entry(DATA_SET, 1, 2'd3);
        word_read_entry(DATA_SET, 2, 2'd2);
        word_read_entry(DATA_SET, 3, 2'd0);
    endtask

    task automatic clear_inputs();
        {dir_match_i, dir_refill_i, dir_updt_i, dir_updt_valid_i, dir_updt_dirty_i} = '0;
        {data_read_i, data_write_i, data_refill_i} = '0;
        {dir_match_set_i, dir_refill_set_i, dir_updt_set_i} = '0;
        {data_read_set_i, data_write_set_i, data_refill_set_i} = '0;
        {dir_match_tag_i, dir_refill_tag_i, dir_updt_tag_i} = '0;
        {dir_refill_way_i, dir_updt_way_i} = '0;
        {data_read_way_i, data_write_way_i, data_refill_way_i} = '0;
        {data_read_word_i, data_write_word_i, data_refill_word_i} = '0;
        {data_write_data_i, data_refill_data_i, data_write_be_i} = '0;
    endtask

    task automatic drive_row(row_t r);
        clear_inputs();
        case (r.op)
            OP_MATCH: begin
                dir_match_i     = 1'b1;
                dir_match_set_i = r.set;
                dir_match_tag_i = r.tag;
            end
            OP_REFILL: begin
                dir_refill_i     = 1'b1;
                dir_refill_set_i = r.set;
                dir_refill_way_i = way_vec_t'(1) << r.way;
                dir_refill_tag_i = r.tag;
            end
            OP_UPDT: begin
                dir_updt_i       = 1'b1;
                dir_updt_set_i   = r.set;
                dir_updt_way_i   = way_vec_t'(1) << r.way;
                dir_updt_valid_i = r.valid;
                dir_updt_dirty_i = r.dirty;
                dir_updt_tag_i   = r.tag;
            end
            OP_FILL: begin
                data_refill_i      = 1'b1;
                data_refill_set_i  = r.set;
                data_refill_word_i = r.word;
                data_refill_way_i  = way_vec_t'(1) << r.way;
                data_refill_data_i = r.data;
            end
            default: begin
            end
        endcase
        if (r.op == OP_WRITE || r.op == OP_RDWR) begin
            data_write_i      = 1'b1;
            data_write_set_i  = r.set;
            data_write_word_i = r.word;
            data_write_way_i  = way_vec_t'(1) << r.way;
            data_write_data_i = r.data;
            data_write_be_i   = r.be;
        end
        if (r.op == OP_READ || r.op == OP_RDWR) begin
            data_read_i      = 1'b1;
            data_read_set_i  = r.set;
            data_read_word_i = r.rd_word;
            data_read_way_i  = way_vec_t'(1) << r.rd_way;
        end
    endtask

    task automatic compare_value(string name, logic [31:0] got, logic [31:0] exp, string where);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("** Error: %s = %h, expected %h (%s)", name, got, exp, where);
        end
    endtask

    // Registered results and the conflict flag of the previous row
    task automatic check_row(row_t r, int idx);
        string where;
        where = $sformatf("row %0d", idx);
        if (r.op == OP_MATCH) begin
            compare_value("dir_hit_way_o", 32'(dir_hit_way_o), 32'(r.exp_hit), where);
            compare_value("dir_hit_dirty_o", 32'(dir_hit_dirty_o), 32'(r.exp_dirty), where);
            compare_value("dir_victim_way_o", 32'(dir_victim_way_o), 32'(r.exp_victim), where);
        end
        if (r.op == OP_READ || r.op == OP_RDWR) begin
            compare_value("data_read_data_o", data_read_data_o, r.exp_data, where);
        end
        compare_value("rd_wr_conflict_o", 32'(rd_wr_conflict_o), 32'(r.exp_conf), where);
    endtask

    initial begin : main
        int rise_cycle;
        clk_i      = 1'b0;
        rst_ni     = 1'b0;
        errors     = 0;
        checks     = 0;
        table_done = 1'b0;
        lfsr       = 32'h212b;
        clear_inputs();
        build_table();
        table_done = 1'b1;
        repeat (RST_CYCLES) @(posedge clk_i);
        @(negedge clk_i);
        compare_value("ready_o", 32'(ready_o), 32'd0, "reset");
        compare_value("dir_hit_way_o", 32'(dir_hit_way_o), 32'd0, "reset");
        compare_value("data_read_data_o", data_read_data_o, 32'd0, "reset");
        rst_ni = 1'b1;
        // One init cycle per set
        rise_cycle = 0;
        for (int c = 1; c <= INIT_LIMIT && rise_cycle == 0; c++) begin
            @(negedge clk_i);
            if (ready_o) begin
                rise_cycle = c;
            end
        end
        checks++;
        assert (rise_cycle != 0) else begin
            errors++;
            $display("ready_o did not rise within %0d cycles after reset", INIT_LIMIT);
        end
        if (rise_cycle != 0) begin
            compare_value("ready_o rise cycle", 32'(rise_cycle), `MC_SETS, "init");
        end
        for (int i = 0; i <= rows.size(); i++) begin
            @(negedge clk_i);
            if (i > 0) begin
                check_row(rows[i-1], i - 1);
            end
            if (i < rows.size()) begin
                drive_row(rows[i]);
            end else begin
                clear_inputs();
            end
        end
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

    initial begin : watchdog
        wait (table_done);
        #((rows.size() * 200) + (RST_CYCLES + INIT_LIMIT + 2) * 2 * CLK_HALF);
        $display("Watchdog expired before the table was applied");
        $display("tests failed");
        $finish;
    end

endmodule

//--- memctrl_top.f
+incdir+.
memctrl_pkg.sv
dir_state_if.sv
cache_sram.sv
dir_ctrl.sv
victim_sel.sv
data_ctrl.sv
memctrl_top.sv
memctrl_assertions.sv
tb_memctrl.sv

//--- run.sh
#!/bin/bash
# Compile and run the memctrl testbench with Verilator
set -eo pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_memctrl \
    -f memctrl_top.f

./obj_dir/Vtb_memctrl 2>&1 | tee sim.log

if grep -q "tests failed" sim.log; then
    echo "Simulation reported a failure, see sim.log"
    exit 1
fi

echo "Simulation finished without failure"
